//--- dv/fetchFrontEndTb.sv
//////////////////////////////////////////////////
// Fetch front end testbench
// Clock, reset, memory model with random latency
// Lane monitor, reference PC stream, directed tests
//////////////////////////////////////////////////
`include "fetchUnit_defs.svh"

module fetchFrontEndTb import fetchTypes::*; ();

    localparam logic [31:0] InsnKey = 32'hA5A5_0000;
    localparam int WaitLimit = 400;

    logic clk;
    logic rstN;
    logic decStall;
    logic beRedirect;
    pcT   beRedirectPc;
    logic brUpdate;
    pcT   brUpdatePc;
    logic brUpdateTaken;
    pcT   brUpdateTarget;
    logic memReq;
    pcT   memAddr;
    logic memValid;
    lineT memData;
    logic outValid [`FETCH_WIDTH];
    pcT   outPc [`FETCH_WIDTH];
    insnT outInsn [`FETCH_WIDTH];
    logic outPredTaken [`FETCH_WIDTH];
    pcT   outPredTarget [`FETCH_WIDTH];

    // Delivered lanes in arrival order
    pcT   gotPc [$];
    insnT gotInsn [$];
    logic gotTaken [$];
    pcT   gotTarget [$];
    int   gotLane [$];

    // Memory model state
    logic [31:0] seed = 32'he327_e99c;
    logic memBusy;
    int   memLeft;
    pcT   memBase;
    int   memReqs;

    // Reference model of the one trained branch
    pcT   brPc;
    pcT   brTarget;
    logic [1:0] brCtr;
    logic brValid;

    fetchFrontEnd UUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Both words of the line at a group base
    function automatic lineT lineFor(pcT base);
        return {(base + 32'd4) ^ InsnKey, base ^ InsnKey};
    endfunction

    function automatic logic expectTaken(pcT pc);
        return brValid && pc == brPc && brCtr >= 2'd2;
    endfunction

    // Same saturating rule as the predictor counters
    function automatic void modelUpdate(logic taken);
        if (taken && brCtr != 2'b11) begin
            brCtr = brCtr + 2'd1;
        end else if (!taken && brCtr != 2'b00) begin
            brCtr = brCtr - 2'd1;
        end
        if (taken) begin
            brValid = 1'b1;
        end
    endfunction

    task automatic checkEq(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic timeoutFail(string what);
        $display("Timed out waiting for %s", what);
        $display("test failed");
        $fatal(1);
    endtask

    // Answers one request at a time after 1 to 6 cycles
    always @(negedge clk) begin
        memValid = 1'b0;
        if (memBusy) begin
            memLeft--;
            if (memLeft == 0) begin
                memValid = 1'b1;
                memData = lineFor(memBase);
                memBusy = 1'b0;
            end
        end else if (rstN && memReq) begin
            memBusy = 1'b1;
            memBase = memAddr;
            memLeft = 1 + int'(nextRand() % 6);
        end
    end

    // Lane 0 is pushed before lane 1
    always @(posedge clk) begin
        if (rstN) begin
            // One count per request pulse
            if (memReq) begin
                memReqs++;
            end
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (outValid[i]) begin
                    gotPc.push_back(outPc[i]);
                    gotInsn.push_back(outInsn[i]);
                    gotTaken.push_back(outPredTaken[i]);
                    gotTarget.push_back(outPredTarget[i]);
                    gotLane.push_back(i);
                end
            end
        end
    end

    task automatic redirectTo(pcT pc);
        @(negedge clk);
        beRedirect = 1'b1;
        beRedirectPc = pc;
        gotPc.delete();
        gotInsn.delete();
        gotTaken.delete();
        gotTarget.delete();
        gotLane.delete();
        @(negedge clk);
        beRedirect = 1'b0;
        memReqs = 0;
    endtask

    task automatic trainBranch(pcT pc, logic taken, pcT target);
        @(negedge clk);
        brUpdate = 1'b1;
        brUpdatePc = pc;
        brUpdateTaken = taken;
        brUpdateTarget = target;
        @(negedge clk);
        brUpdate = 1'b0;
    endtask

    // Walks the reference stream over the first n delivered lanes
    task automatic checkStream(pcT start, int n);
        int t;
        pcT exp;
        logic tk;
        t = 0;
        while (gotPc.size() < n && t < WaitLimit) begin
            @(negedge clk);
            t++;
        end
        if (gotPc.size() < n) begin
            timeoutFail("delivered lanes");
        end
        exp = start;
        for (int k = 0; k < n; k++) begin
            tk = expectTaken(exp);
            checkEq("outPc", gotPc[k], exp);
            checkEq("lane", gotLane[k], exp[2]);
            checkEq("outInsn", gotInsn[k], exp ^ InsnKey);
            checkEq("outPredTaken", gotTaken[k], tk);
            checkEq("outPredTarget", gotTarget[k], tk ? brTarget : exp + 32'd4);
            exp = tk ? brTarget : exp + 32'd4;
        end
    endtask

    task automatic sequentialRefetch();
        checkStream(`RESET_PC, 16);
        redirectTo(`RESET_PC);
        checkStream(`RESET_PC, 16);
        checkEq("memReqCount", memReqs, 0);
    endtask

    task automatic takenAfterTraining();
        trainBranch(brPc, 1'b1, brTarget);
        modelUpdate(1'b1);
        trainBranch(brPc, 1'b1, brTarget);
        modelUpdate(1'b1);
        redirectTo(`RESET_PC);
        checkStream(`RESET_PC, 8);
    endtask

    task automatic midGroupRedirect();
        redirectTo(`RESET_PC + 32'h84);
        checkStream(`RESET_PC + 32'h84, 6);
    endtask

    task automatic holdUnderDecStall();
        int t;
        pcT snapPc [`FETCH_WIDTH];
        insnT snapInsn [`FETCH_WIDTH];
        logic snapTaken [`FETCH_WIDTH];
        pcT snapTarget [`FETCH_WIDTH];
        redirectTo(`RESET_PC);
        t = 0;
        while (!(outValid[0] && outPc[0] == brPc) && t < WaitLimit) begin
            @(negedge clk);
            t++;
        end
        if (!(outValid[0] && outPc[0] == brPc)) begin
            timeoutFail("branch group in fetch");
        end
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            snapPc[i] = outPc[i];
            snapInsn[i] = outInsn[i];
            snapTaken[i] = outPredTaken[i];
            snapTarget[i] = outPredTarget[i];
        end
        decStall = 1'b1;
        // Untrain the branch while the group is held
        for (int c = 0; c < 8; c++) begin
            @(negedge clk);
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                checkEq("outValid", outValid[i], 1'b0);
                checkEq("outPc", outPc[i], snapPc[i]);
                checkEq("outInsn", outInsn[i], snapInsn[i]);
                checkEq("outPredTaken", outPredTaken[i], snapTaken[i]);
                checkEq("outPredTarget", outPredTarget[i], snapTarget[i]);
            end
            brUpdate = (c < 2);
            brUpdatePc = brPc;
            brUpdateTaken = 1'b0;
        end
        brUpdate = 1'b0;
        decStall = 1'b0;
        checkStream(`RESET_PC, 7);
        modelUpdate(1'b0);
        modelUpdate(1'b0);
    endtask

    task automatic redirectDuringMiss();
        int t;
        redirectTo(32'h0000_2000);
        t = 0;
        while (!memReq && t < WaitLimit) begin
            @(negedge clk);
            t++;
        end
        if (!memReq) begin
            timeoutFail("miss request");
        end
        redirectTo(32'h0000_3008);
        checkStream(32'h0000_3008, 6);
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        decStall = 1'b0;
        beRedirect = 1'b0;
        beRedirectPc = '0;
        brUpdate = 1'b0;
        brUpdatePc = '0;
        brUpdateTaken = 1'b0;
        brUpdateTarget = '0;
        memValid = 1'b0;
        memData = '0;
        memBusy = 1'b0;
        memLeft = 0;
        memBase = '0;
        memReqs = 0;
        brPc = `RESET_PC + 32'h10;
        brTarget = `RESET_PC + 32'h40;
        brCtr = 2'b01;
        brValid = 1'b0;
        repeat (5) @(negedge clk);
        rstN = 1'b1;
        sequentialRefetch();
        takenAfterTraining();
        midGroupRedirect();
        holdUnderDecStall();
        redirectDuringMiss();
        $display("test passed");
        $finish;
    end

endmodule

//--- fetchFrontEnd.f
+incdir+logic
logic/fetchTypes.sv
logic/nextPcStage.sv
logic/fetchStage.sv
logic/fetchControl.sv
logic/instCache.sv
logic/branchPredictor.sv
logic/fetchFrontEnd.sv
dv/fetchFrontEndTb.sv

//--- logic/branchPredictor.sv
//////////////////////////////////////////////////
// Branch predictor
// Per-lane bimodal counters with a BTB
// Registered read address, back-end training
//////////////////////////////////////////////////
`include "fetchUnit_defs.svh"

module branchPredictor import fetchTypes::*; (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  pcT   groupPc,
    output logic predTaken [`FETCH_WIDTH],
    output pcT   predTarget [`FETCH_WIDTH],
    input  logic brUpdate,
    input  pcT   brUpdatePc,
    input  logic brUpdateTaken,
    input  pcT   brUpdateTarget
);

    localparam int LaneBits = $clog2(`INSN_BYTES);
    localparam int OffsetBits = $clog2(`FETCH_WIDTH * `INSN_BYTES);
    localparam int IndexBits = $clog2(`BP_ENTRIES);
    localparam int TagBits = `ADDR_WIDTH - IndexBits - OffsetBits;

    // One table per lane
    logic [1:0] counter [`FETCH_WIDTH][`BP_ENTRIES];
    logic btbValid [`FETCH_WIDTH][`BP_ENTRIES];
    logic [TagBits-1:0] btbTag [`FETCH_WIDTH][`BP_ENTRIES];
    pcT btbTarget [`FETCH_WIDTH][`BP_ENTRIES];

    pcT rdPc;
    logic [IndexBits-1:0] rdIndex;
    logic [TagBits-1:0] rdTag;
    logic [IndexBits-1:0] upIndex;
    logic [TagBits-1:0] upTag;
    logic [OffsetBits-LaneBits-1:0] upLane;

    assign rdIndex = rdPc[OffsetBits +: IndexBits];
    assign rdTag = rdPc[`ADDR_WIDTH-1 -: TagBits];
    // Lane picked by the word position inside the group
    assign upLane = brUpdatePc[LaneBits +: OffsetBits-LaneBits];
    assign upIndex = brUpdatePc[OffsetBits +: IndexBits];
    assign upTag = brUpdatePc[`ADDR_WIDTH-1 -: TagBits];

    // Address follows the group entering fetch
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdPc <= `RESET_PC;
        end else if (!stall) begin
            rdPc <= groupPc;
        end
    end

    // Taken needs a BTB hit and a counter of 2 or more
    always_comb begin
        for (int l = 0; l < `FETCH_WIDTH; l++) begin
            predTaken[l] = btbValid[l][rdIndex] && (btbTag[l][rdIndex] == rdTag)
                && counter[l][rdIndex][1];
            predTarget[l] = btbTarget[l][rdIndex];
        end
    end

    // Counters start weakly not-taken
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int l = 0; l < `FETCH_WIDTH; l++) begin
                for (int e = 0; e < `BP_ENTRIES; e++) begin
                    counter[l][e] <= 2'b01;
                    btbValid[l][e] <= 1'b0;
                end
            end
        end else if (brUpdate) begin
            // Saturating step toward the outcome
            if (brUpdateTaken && counter[upLane][upIndex] != 2'b11) begin
                counter[upLane][upIndex] <= counter[upLane][upIndex] + 2'd1;
            end else if (!brUpdateTaken && counter[upLane][upIndex] != 2'b00) begin
                counter[upLane][upIndex] <= counter[upLane][upIndex] - 2'd1;
            end
            if (brUpdateTaken) begin
                btbValid[upLane][upIndex] <= 1'b1;
            end
        end
    end

    // Target only learned from taken outcomes
    always_ff @(posedge clk) begin
        if (brUpdate && brUpdateTaken) begin
            btbTag[upLane][upIndex] <= upTag;
            btbTarget[upLane][upIndex] <= brUpdateTarget;
        end
    end

endmodule

//--- logic/fetchControl.sv
//////////////////////////////////////////////////
// Pipeline control
// Stall and clear levels, refill FSM
//////////////////////////////////////////////////
module fetchControl import fetchTypes::*; (
    input  logic clk,
    input  logic rstN,
    input  logic missBubble,
    input  logic decStall,
    input  logic beRedirect,
    input  pcT   icAddr,
    input  logic memValid,
    output logic memReq,
    output pcT   memAddr,
    output logic refillWe,
    output logic stall,
    output logic clear
);

    ctrlStateT state;
    ctrlStateT stateNext;
    // Set when a redirect hits while memory is still busy
    logic abandoned;

    assign clear = beRedirect;
    // Redirect wins over any stall so both stages reload at once
    assign stall = (missBubble || decStall) && !beRedirect;

    // One request per miss, only from idle
    assign memReq = (state == idle) && missBubble && !beRedirect;
    assign memAddr = icAddr;
    // Line goes in as memory answers, stale answers are dropped
    assign refillWe = (state == missWait) && memValid && !abandoned && !beRedirect;

    always_comb begin
        stateNext = state;
        case (state)
            idle: begin
                if (memReq) begin
                    stateNext = missWait;
                end
            end
            missWait: begin
                if (memValid) begin
                    stateNext = refillWe ? refill : idle;
                end
            end
            // Hit shows up in this cycle
            refill: stateNext = idle;
            default: stateNext = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= idle;
            abandoned <= 1'b0;
        end else begin
            state <= stateNext;
            if (stateNext == idle) begin
                abandoned <= 1'b0;
            end else if (beRedirect) begin
                abandoned <= 1'b1;
            end
        end
    end

    // Refilled line must hit while fetch still holds the group
    refillHitA: assert property (@(posedge clk) disable iff (!rstN)
        (state == refill) |-> !missBubble);

endmodule

//--- logic/fetchFrontEnd.sv
//////////////////////////////////////////////////
// Fetch front end top level
// Next-PC and fetch stages, control, cache, predictor
//////////////////////////////////////////////////
`include "fetchUnit_defs.svh"

module fetchFrontEnd import fetchTypes::*; (
    input  logic clk,
    input  logic rstN,
    input  logic decStall,
    input  logic beRedirect,
    input  pcT   beRedirectPc,
    input  logic brUpdate,
    input  pcT   brUpdatePc,
    input  logic brUpdateTaken,
    input  pcT   brUpdateTarget,
    output logic memReq,
    output pcT   memAddr,
    input  logic memValid,
    input  lineT memData,
    output logic outValid [`FETCH_WIDTH],
    output pcT   outPc [`FETCH_WIDTH],
    output insnT outInsn [`FETCH_WIDTH],
    output logic outPredTaken [`FETCH_WIDTH],
    output pcT   outPredTarget [`FETCH_WIDTH]
);

    // Pipeline control levels
    logic stall;
    logic clear;
    logic missBubble;
    logic refillWe;
    // Next-PC to fetch
    logic groupValid;
    pcT   groupPc;
    logic groupStartLane;
    // Fetch back to next-PC
    logic fetchRedirect;
    pcT   fetchRedirectPc;
    // Predictor and cache
    logic predTaken [`FETCH_WIDTH];
    pcT   predTarget [`FETCH_WIDTH];
    logic icRe;
    pcT   icAddr;
    logic icHit;
    lineT icLine;

    nextPcStage nextPc (
        .clk, .rstN, .stall, .clear, .beRedirect, .beRedirectPc,
        .fetchRedirect, .fetchRedirectPc, .groupValid, .groupPc, .groupStartLane
    );

    fetchStage fetch (
        .clk, .rstN, .stall, .clear, .groupValid, .groupPc, .groupStartLane,
        .predTaken, .predTarget, .icHit, .icLine, .icRe, .icAddr,
        .fetchRedirect, .fetchRedirectPc, .missBubble,
        .outValid, .outPc, .outInsn, .outPredTaken, .outPredTarget
    );

    fetchControl control (
        .clk, .rstN, .missBubble, .decStall, .beRedirect, .icAddr, .memValid,
        .memReq, .memAddr, .refillWe, .stall, .clear
    );

    instCache icache (
        .clk, .rstN, .icRe, .icAddr, .icHit, .icLine, .refillWe, .memData
    );

    branchPredictor bpred (
        .clk, .rstN, .stall, .groupPc, .predTaken, .predTarget,
        .brUpdate, .brUpdatePc, .brUpdateTaken, .brUpdateTarget
    );

endmodule

//--- logic/fetchStage.sv
//////////////////////////////////////////////////
// Fetch stage
// Lane pipeline registers, prediction capture
// Lane squash, cache lookup and group output
//////////////////////////////////////////////////
`include "fetchUnit_defs.svh"

module fetchStage import fetchTypes::*; (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic clear,
    input  logic groupValid,
    input  pcT   groupPc,
    input  logic groupStartLane,
    input  logic predTaken [`FETCH_WIDTH],
    input  pcT   predTarget [`FETCH_WIDTH],
    input  logic icHit,
    input  lineT icLine,
    output logic icRe,
    output pcT   icAddr,
    output logic fetchRedirect,
    output pcT   fetchRedirectPc,
    output logic missBubble,
    output logic outValid [`FETCH_WIDTH],
    output pcT   outPc [`FETCH_WIDTH],
    output insnT outInsn [`FETCH_WIDTH],
    output logic outPredTaken [`FETCH_WIDTH],
    output pcT   outPredTarget [`FETCH_WIDTH]
);

    localparam int InsnBits = `INSN_BYTES * 8;

    logic laneValid [`FETCH_WIDTH];
    pcT   lanePc [`FETCH_WIDTH];
    logic regStall;
    logic beginStall;
    logic capTaken [`FETCH_WIDTH];
    pcT   capTarget [`FETCH_WIDTH];
    pcT   effTarget [`FETCH_WIDTH];
    logic laneTaken [`FETCH_WIDTH];
    logic squash [`FETCH_WIDTH];
    logic seenTaken;

    // Predictor output may move during a stall
    // so the copy from the first stalled cycle is kept
    assign beginStall = stall && !regStall;

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            effTarget[i] = regStall ? capTarget[i] : predTarget[i];
            laneTaken[i] = laneValid[i] && (regStall ? capTaken[i] : predTaken[i]);
        end
    end

    // First taken lane redirects, later lanes are squashed
    always_comb begin
        seenTaken = 1'b0;
        fetchRedirect = 1'b0;
        fetchRedirectPc = effTarget[0];
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            squash[i] = seenTaken && laneValid[i];
            if (laneTaken[i] && !seenTaken) begin
                fetchRedirect = 1'b1;
                fetchRedirectPc = effTarget[i];
            end
            seenTaken = seenTaken || laneTaken[i];
        end
    end

    // Lane valid bits and stall tracking
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regStall <= 1'b0;
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                laneValid[i] <= 1'b0;
                capTaken[i] <= 1'b0;
            end
        end else begin
            regStall <= stall;
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (clear) begin
                    laneValid[i] <= 1'b0;
                end else if (!stall) begin
                    laneValid[i] <= groupValid && (i >= int'(groupStartLane));
                end else if (squash[i]) begin
                    // Held group keeps only the lanes up to the taken branch
                    laneValid[i] <= 1'b0;
                end
                if (beginStall) begin
                    capTaken[i] <= predTaken[i];
                end
            end
        end
    end

    // Lane PCs and captured targets
    always_ff @(posedge clk) begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (!stall) begin
                lanePc[i] <= groupPc + pcT'(i * `INSN_BYTES);
            end
            if (beginStall) begin
                capTarget[i] <= predTarget[i];
            end
        end
    end

    // Whole group comes from one line at the group base
    assign icRe = laneValid[0] || laneValid[1];
    assign icAddr = lanePc[0];
    assign missBubble = icRe && !icHit;

    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            outValid[i] = laneValid[i] && !squash[i] && !stall && !clear;
            outPc[i] = lanePc[i];
            outInsn[i] = icLine[i*InsnBits +: InsnBits];
            outPredTaken[i] = laneTaken[i] && !squash[i];
            // Not taken points at the next word
            outPredTarget[i] = laneTaken[i] ? effTarget[i] : lanePc[i] + pcT'(`INSN_BYTES);
        end
    end

    // Control must hold the stage on every miss
    noOutOnMissA: assert property (@(posedge clk) disable iff (!rstN)
        missBubble |-> !(outValid[0] || outValid[1]));

endmodule

//--- logic/fetchTypes.sv
//////////////////////////////////////////////////
// Package fetchTypes
// Vector types for PCs, instructions, cache lines
// State encoding of the refill FSM
//////////////////////////////////////////////////
`include "fetchUnit_defs.svh"

package fetchTypes;

    // Fetch address, also the physical address
    typedef logic [`ADDR_WIDTH-1:0] pcT;

    // One instruction word
    typedef logic [`INSN_BYTES*8-1:0] insnT;

    // One cache line holds a whole fetch group
    // Lane 0 sits in the low word
    typedef logic [`FETCH_WIDTH*`INSN_BYTES*8-1:0] lineT;

    // Refill FSM of the pipeline control
    typedef enum logic [1:0] {
        idle,
        missWait,
        refill
    } ctrlStateT;

endpackage

//--- logic/fetchUnit_defs.svh
//////////////////////////////////////////////////
// Fetch front end configuration macros
// Lane count, address and instruction sizes
// Cache and predictor sizes, reset vector
//////////////////////////////////////////////////
`ifndef FETCH_UNIT_DEFS_SVH
`define FETCH_UNIT_DEFS_SVH

// Lanes per fetch group
`define FETCH_WIDTH 2
// Address and instruction sizes
`define ADDR_WIDTH  32
`define INSN_BYTES  4
// Storage sizes
`define IC_LINES    16
`define BP_ENTRIES  32
// First fetch address on a group boundary
`define RESET_PC    32'h0000_1000

`endif

//--- logic/instCache.sv
//////////////////////////////////////////////////
// Instruction cache
// Direct-mapped, one fetch group per line
// Combinational lookup, refill write
//////////////////////////////////////////////////
`include "fetchUnit_defs.svh"

module instCache import fetchTypes::*; (
    input  logic clk,
    input  logic rstN,
    input  logic icRe,
    input  pcT   icAddr,
    output logic icHit,
    output lineT icLine,
    input  logic refillWe,
    input  lineT memData
);

    // Address split
    localparam int OffsetBits = $clog2(`FETCH_WIDTH * `INSN_BYTES);
    localparam int IndexBits = $clog2(`IC_LINES);
    localparam int TagBits = `ADDR_WIDTH - IndexBits - OffsetBits;

    // Line storage
    lineT dataArray [`IC_LINES];
    logic [TagBits-1:0] tagArray [`IC_LINES];
    logic [`IC_LINES-1:0] validBits;

    logic [IndexBits-1:0] index;
    logic [TagBits-1:0] tag;

    assign index = icAddr[OffsetBits +: IndexBits];
    assign tag = icAddr[`ADDR_WIDTH-1 -: TagBits];

    // Hit needs a read, a valid line and a matching tag
    assign icHit = icRe && validBits[index] && (tagArray[index] == tag);
    // Data goes out regardless, fetch qualifies it with the hit
    assign icLine = dataArray[index];

    // Valid bits start cleared
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validBits <= '0;
        end else if (refillWe) begin
            validBits[index] <= 1'b1;
        end
    end

    // Refill lands at the address still held in fetch
    always_ff @(posedge clk) begin
        if (refillWe) begin
            dataArray[index] <= memData;
            tagArray[index] <= tag;
        end
    end

endmodule

//--- logic/nextPcStage.sv
//////////////////////////////////////////////////
// Next-PC stage
// Fetch PC register and next fetch address choice
//////////////////////////////////////////////////
`include "fetchUnit_defs.svh"

module nextPcStage import fetchTypes::*; (
    input  logic clk,
    input  logic rstN,
    input  logic stall,
    input  logic clear,
    input  logic beRedirect,
    input  pcT   beRedirectPc,
    input  logic fetchRedirect,
    input  pcT   fetchRedirectPc,
    output logic groupValid,
    output pcT   groupPc,
    output logic groupStartLane
);

    localparam int GroupBytes = `FETCH_WIDTH * `INSN_BYTES;
    localparam int LaneBits = $clog2(`INSN_BYTES);

    pcT   pcReg;
    pcT   nextPc;
    logic started;

    // Group base drives both fetch and the predictor
    assign groupPc = pcReg & ~pcT'(GroupBytes - 1);
    // Entry into the second word leaves lane 0 empty
    assign groupStartLane = pcReg[LaneBits];
    // Fall-through group is dropped behind a taken branch
    // A back-end redirect kills the wrong-path group here too
    assign groupValid = started && !fetchRedirect && !clear;

    // Back end first, then predicted target, then next group
    always_comb begin
        if (beRedirect) begin
            nextPc = beRedirectPc;
        end else if (fetchRedirect) begin
            nextPc = fetchRedirectPc;
        end else begin
            nextPc = groupPc + pcT'(GroupBytes);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcReg <= `RESET_PC;
            started <= 1'b0;
        end else if (!started) begin
            // Reset vector becomes a live group one cycle after release
            started <= 1'b1;
        end else if (!stall) begin
            pcReg <= nextPc;
        end
    end

    // Every loaded fetch address stays on a word boundary
    pcAlignedA: assert property (@(posedge clk) disable iff (!rstN)
        started && !stall |=> pcReg[LaneBits-1:0] == '0);

endmodule

//--- runSim.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f fetchFrontEnd.f \
    --top-module fetchFrontEndTb -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "test passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
